/* verilog/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// operand and result width
`define EXEC_DATA_WIDTH 16

// instruction word width
`define EXEC_IR_WIDTH 16

// operation field inside the instruction word
`define EXEC_OPC_LSB 4
`define EXEC_OPC_MSB 6

// set for two-operand form, clear for one-operand form
`define EXEC_TWO_OPERAND_BIT 1

`endif

/* verilog/exec_pkg.sv */
`include "exec_params.svh"

package exec_pkg;

    typedef logic [`EXEC_DATA_WIDTH-1:0] word_t;
    typedef logic [`EXEC_IR_WIDTH-1:0]   ir_t;

    // alu operation select
    typedef enum logic [3:0] {
        OP_ADC = 4'd0,
        OP_AND = 4'd1,
        OP_OR  = 4'd2,
        OP_SHL = 4'd3,
        OP_SHR = 4'd4,
        OP_SAR = 4'd5
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_T1_WRITE = 3'd1,
        ST_T2_WRITE = 3'd2,
        ST_STORE    = 3'd3,
        ST_EXEC     = 3'd4
    } exec_state_e;

    // held stable by the requester until done
    typedef struct packed {
        ir_t   ir;
        word_t t1;
        word_t t2;
        logic  carry;
    } exec_req_t;

    typedef struct packed {
        word_t result;
        logic  carry_out;
        logic  illegal;
    } exec_resp_t;

    typedef struct packed {
        logic we;
        logic oe;
    } reg_ctrl_t;

    typedef struct packed {
        alu_op_e op;
        logic    oe;
    } alu_ctrl_t;

endpackage

/* verilog/operand_register.sv */
`timescale 1ns/1ps

module operand_register
    import exec_pkg::*;
(
    input  logic      i_w_clk,
    input  logic      i_w_reset,
    input  reg_ctrl_t i_ctrl,
    input  word_t     i_data,
    output word_t     o_data
);

    word_t data_q;

    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            data_q <= '0;
        end else if (i_ctrl.we) begin
            data_q <= i_data;
        end
    end

    // reads zero when not enabled
    // a one-operand instruction sees a zero second operand this way
    assign o_data = i_ctrl.oe ? data_q : '0;

endmodule

/* verilog/execute_alu.sv */
`timescale 1ns/1ps

module execute_alu
    import exec_pkg::*;
(
    input  alu_ctrl_t i_ctrl,
    input  word_t     i_in1,
    input  word_t     i_in2,
    input  logic      i_carry,
    output word_t     o_result,
    output logic      o_carry
);

    localparam int TOP = $bits(word_t) - 1;

    always_comb begin
        o_result = '0;
        o_carry  = 1'b0;
        if (i_ctrl.oe) begin
            case (i_ctrl.op)
                OP_ADC: begin
                    // carry out is the bit above the word
                    {o_carry, o_result} = i_in1 + i_in2 + i_carry;
                end
                OP_AND: begin
                    o_result = i_in1 & i_in2;
                    o_carry  = 1'b0;
                end
                OP_OR: begin
                    o_result = i_in1 | i_in2;
                    o_carry  = 1'b0;
                end
                OP_SHL: begin
                    o_result = {i_in1[TOP-1:0], 1'b0};
                    o_carry  = i_in1[TOP];
                end
                OP_SHR: begin
                    o_result = {1'b0, i_in1[TOP:1]};
                    o_carry  = i_in1[0];
                end
                OP_SAR: begin
                    // sign bit repeats into the top
                    o_result = {i_in1[TOP], i_in1[TOP:1]};
                    o_carry  = i_in1[0];
                end
                default: begin
                    o_result = '0;
                    o_carry  = 1'b0;
                end
            endcase
        end
    end

endmodule

/* verilog/execute_sequencer.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module execute_sequencer
    import exec_pkg::*;
(
    input  logic      i_w_clk,
    input  logic      i_w_reset,
    input  logic      i_start,
    input  ir_t       i_ir,
    output reg_ctrl_t o_t1_ctrl,
    output reg_ctrl_t o_t2_ctrl,
    output alu_ctrl_t o_alu_ctrl,
    output logic      o_busy,
    output logic      o_done,
    output logic      o_illegal
);

    exec_state_e state;
    exec_state_e next_state;

    logic [`EXEC_OPC_MSB-`EXEC_OPC_LSB:0] opc;
    logic two_op;
    alu_op_e dec_op;
    logic dec_legal;

    assign opc    = i_ir[`EXEC_OPC_MSB:`EXEC_OPC_LSB];
    assign two_op = i_ir[`EXEC_TWO_OPERAND_BIT];

    // same field decodes to different ops by operand form
    always_comb begin
        dec_op    = OP_ADC;
        dec_legal = 1'b1;
        case (opc)
            3'b100: dec_op = OP_ADC;
            3'b001: dec_op = two_op ? OP_AND : OP_SHL;
            3'b101: dec_op = two_op ? OP_OR : OP_SHR;
            3'b011: dec_op = OP_SAR;
            default: dec_legal = 1'b0;
        endcase
    end

    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        o_t1_ctrl.we   = 1'b0;
        o_t1_ctrl.oe   = 1'b0;
        o_t2_ctrl.we   = 1'b0;
        o_t2_ctrl.oe   = 1'b0;
        o_alu_ctrl.op  = OP_ADC;
        o_alu_ctrl.oe  = 1'b0;
        o_illegal      = 1'b0;

        case (state)
            ST_IDLE: begin
                if (i_start) begin
                    next_state = ST_T1_WRITE;
                end
            end

            ST_T1_WRITE: begin
                o_t1_ctrl.we = 1'b1;
                // one-operand form skips t2
                next_state   = two_op ? ST_T2_WRITE : ST_STORE;
            end

            ST_T2_WRITE: begin
                o_t2_ctrl.we = 1'b1;
                next_state   = ST_STORE;
            end

            ST_STORE: begin
                next_state = ST_EXEC;
            end

            ST_EXEC: begin
                o_t1_ctrl.oe  = 1'b1;
                o_t2_ctrl.oe  = two_op;
                o_alu_ctrl.op = dec_op;
                // illegal code keeps the result at zero
                o_alu_ctrl.oe = dec_legal;
                o_illegal     = !dec_legal;
                next_state    = ST_IDLE;
            end

            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    assign o_busy = (state != ST_IDLE);
    assign o_done = (state == ST_EXEC);

endmodule

/* verilog/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
    import exec_pkg::*;
(
    input  logic       i_w_clk,
    input  logic       i_w_reset,
    input  logic       i_start,
    input  exec_req_t  i_req,
    output logic       o_busy,
    output logic       o_done,
    output exec_resp_t o_resp
);

    reg_ctrl_t t1_ctrl;
    reg_ctrl_t t2_ctrl;
    alu_ctrl_t alu_ctrl;
    word_t     t1_data;
    word_t     t2_data;
    word_t     alu_result;
    logic      alu_carry;
    logic      illegal;

    execute_sequencer sequencer (
        .i_w_clk    (i_w_clk),
        .i_w_reset  (i_w_reset),
        .i_start    (i_start),
        .i_ir       (i_req.ir),
        .o_t1_ctrl  (t1_ctrl),
        .o_t2_ctrl  (t2_ctrl),
        .o_alu_ctrl (alu_ctrl),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_illegal  (illegal)
    );

    operand_register t1_reg (
        .i_w_clk   (i_w_clk),
        .i_w_reset (i_w_reset),
        .i_ctrl    (t1_ctrl),
        .i_data    (i_req.t1),
        .o_data    (t1_data)
    );

    operand_register t2_reg (
        .i_w_clk   (i_w_clk),
        .i_w_reset (i_w_reset),
        .i_ctrl    (t2_ctrl),
        .i_data    (i_req.t2),
        .o_data    (t2_data)
    );

    // carry goes straight from the request
    execute_alu alu (
        .i_ctrl   (alu_ctrl),
        .i_in1    (t1_data),
        .i_in2    (t2_data),
        .i_carry  (i_req.carry),
        .o_result (alu_result),
        .o_carry  (alu_carry)
    );

    assign o_resp = '{result: alu_result, carry_out: alu_carry, illegal: illegal};

endmodule

/* verification/execute_unit_properties.sv */
`timescale 1ns/1ps

module execute_unit_properties
    import exec_pkg::*;
(
    input logic       i_w_clk,
    input logic       i_w_reset,
    input logic       i_start,
    input logic       o_busy,
    input logic       o_done,
    input exec_resp_t o_resp
);

    int fail_count = 0;

    property done_single_cycle;
        @(posedge i_w_clk) disable iff (!i_w_reset)
            o_done |=> !o_done;
    endproperty

    property done_while_busy;
        @(posedge i_w_clk) disable iff (!i_w_reset)
            o_done |-> o_busy;
    endproperty

    // accepted start shows up as busy one edge later
    property start_raises_busy;
        @(posedge i_w_clk) disable iff (!i_w_reset)
            (i_start && !o_busy) |=> o_busy;
    endproperty

    property resp_zero_outside_done;
        @(posedge i_w_clk) disable iff (!i_w_reset)
            !o_done |-> (o_resp == '0);
    endproperty

    done_single_cycle_check: assert property (done_single_cycle)
        else begin
            fail_count++;
            $error("o_done stayed high for more than one cycle");
        end

    done_while_busy_check: assert property (done_while_busy)
        else begin
            fail_count++;
            $error("o_done was high while o_busy was low");
        end

    start_raises_busy_check: assert property (start_raises_busy)
        else begin
            fail_count++;
            $error("o_busy did not rise after a start while idle");
        end

    resp_zero_check: assert property (resp_zero_outside_done)
        else begin
            fail_count++;
            $error("o_resp was not zero outside the done cycle");
        end

endmodule

bind execute_unit execute_unit_properties unit_props (.*);

/* verification/execute_unit_tb.sv */
`timescale 1ns/1ps

`include "exec_params.svh"

module execute_unit_tb
    import exec_pkg::*;
();

    localparam int NUM_ROWS    = 15;
    localparam int NUM_RANDOM  = 32;
    localparam int CYCLE_LIMIT = (NUM_ROWS + NUM_RANDOM) * 8 + 40;
    localparam int MSB         = `EXEC_DATA_WIDTH - 1;

    // one request with its expected response
    typedef struct packed {
        exec_req_t req;
        word_t     exp_result;
        logic      exp_carry;
        logic      exp_illegal;
        logic      start_while_busy;
    } row_t;

    logic       i_w_clk;
    logic       i_w_reset;
    logic       i_start;
    exec_req_t  i_req;
    logic       o_busy;
    logic       o_done;
    exec_resp_t o_resp;

    row_t   rows [NUM_ROWS];
    row_t   rand_row;
    integer seed;
    int     cycle_count = 0;

    execute_unit dut (
        .i_w_clk   (i_w_clk),
        .i_w_reset (i_w_reset),
        .i_start   (i_start),
        .i_req     (i_req),
        .o_busy    (o_busy),
        .o_done    (o_done),
        .o_resp    (o_resp)
    );

    initial begin
        i_w_clk = 1'b0;
        forever #20 i_w_clk = ~i_w_clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s: got %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    // run length is bounded by the number of rows
    always @(posedge i_w_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_on_error("timeout: the run did not finish within the cycle limit");
        end
    end

    always @(posedge i_w_clk) begin
        if (dut.unit_props.fail_count != 0) begin
            stop_on_error("a concurrent assertion on the DUT ports failed");
        end
    end

    function automatic ir_t make_ir(input logic [2:0] opc, input logic two_op);
        ir_t ir;
        ir = '0;
        ir[`EXEC_OPC_MSB:`EXEC_OPC_LSB] = opc;
        ir[`EXEC_TWO_OPERAND_BIT] = two_op;
        return ir;
    endfunction

    function automatic row_t make_row(input logic [2:0] opc, input logic two_op,
                                      input word_t t1, input word_t t2, input logic cin,
                                      input word_t res, input logic cout, input logic ill);
        row_t r;
        r.req.ir           = make_ir(opc, two_op);
        r.req.t1           = t1;
        r.req.t2           = t2;
        r.req.carry        = cin;
        r.exp_result       = res;
        r.exp_carry        = cout;
        r.exp_illegal      = ill;
        r.start_while_busy = 1'b0;
        return r;
    endfunction

    // response worked out from the instruction rules
    function automatic exec_resp_t expected_response(input exec_req_t req);
        exec_resp_t r;
        logic [2:0] opc;
        logic       two_op;
        logic [MSB+1:0] sum;
        word_t      a;
        word_t      b;
        opc    = req.ir[`EXEC_OPC_MSB:`EXEC_OPC_LSB];
        two_op = req.ir[`EXEC_TWO_OPERAND_BIT];
        a      = req.t1;
        b      = two_op ? req.t2 : '0;
        r      = '0;
        case (opc)
            3'b100: begin
                sum         = {1'b0, a} + {1'b0, b} + req.carry;
                r.result    = sum[MSB:0];
                r.carry_out = sum[MSB+1];
            end
            3'b001: begin
                if (two_op) begin
                    r.result = a & b;
                end else begin
                    r.result    = a << 1;
                    r.carry_out = a[MSB];
                end
            end
            3'b101: begin
                if (two_op) begin
                    r.result = a | b;
                end else begin
                    r.result    = a >> 1;
                    r.carry_out = a[0];
                end
            end
            3'b011: begin
                r.result    = {a[MSB], a[MSB:1]};
                r.carry_out = a[0];
            end
            default: begin
                r.illegal = 1'b1;
            end
        endcase
        return r;
    endfunction

    task automatic fill_table();
        rows[0]  = make_row(3'b100, 1'b1, 16'h1234, 16'h0101, 1'b0, 16'h1335, 1'b0, 1'b0);
        rows[1]  = make_row(3'b100, 1'b1, 16'hffff, 16'h0001, 1'b0, 16'h0000, 1'b1, 1'b0);
        rows[2]  = make_row(3'b100, 1'b1, 16'hffff, 16'hffff, 1'b1, 16'hffff, 1'b1, 1'b0);
        rows[3]  = make_row(3'b100, 1'b0, 16'h00ff, 16'h5555, 1'b1, 16'h0100, 1'b0, 1'b0);
        rows[4]  = make_row(3'b100, 1'b0, 16'hffff, 16'h1234, 1'b1, 16'h0000, 1'b1, 1'b0);
        rows[5]  = make_row(3'b001, 1'b1, 16'hf0f0, 16'h3c3c, 1'b1, 16'h3030, 1'b0, 1'b0);
        rows[6]  = make_row(3'b101, 1'b1, 16'hf000, 16'h000f, 1'b1, 16'hf00f, 1'b0, 1'b0);
        rows[7]  = make_row(3'b001, 1'b0, 16'h8001, 16'hffff, 1'b0, 16'h0002, 1'b1, 1'b0);
        rows[8]  = make_row(3'b101, 1'b0, 16'h0003, 16'h0000, 1'b0, 16'h0001, 1'b1, 1'b0);
        rows[9]  = make_row(3'b011, 1'b0, 16'h8002, 16'h0000, 1'b0, 16'hc001, 1'b0, 1'b0);
        rows[10] = make_row(3'b011, 1'b1, 16'h4001, 16'haaaa, 1'b0, 16'h2000, 1'b1, 1'b0);
        rows[11] = make_row(3'b000, 1'b1, 16'h1111, 16'h2222, 1'b1, 16'h0000, 1'b0, 1'b1);
        rows[12] = make_row(3'b010, 1'b0, 16'hffff, 16'h0000, 1'b1, 16'h0000, 1'b0, 1'b1);
        rows[13] = make_row(3'b110, 1'b1, 16'h8000, 16'h8000, 1'b0, 16'h0000, 1'b0, 1'b1);
        rows[14] = make_row(3'b111, 1'b0, 16'h0001, 16'h0000, 1'b1, 16'h0000, 1'b0, 1'b1);
        // second start pulsed mid-request
        rows[1].start_while_busy = 1'b1;
        rows[7].start_while_busy = 1'b1;
    endtask

    task automatic build_random_row(output row_t r);
        exec_resp_t exp;
        r.req.ir           = $random(seed);
        r.req.t1           = $random(seed);
        r.req.t2           = $random(seed);
        r.req.carry        = $random(seed);
        r.start_while_busy = $random(seed);
        exp                = expected_response(r.req);
        r.exp_result       = exp.result;
        r.exp_carry        = exp.carry_out;
        r.exp_illegal      = exp.illegal;
    endtask

    task automatic check_idle();
        check_value("o_busy", o_busy, 1'b0);
        check_value("o_done", o_done, 1'b0);
        check_value("o_resp", o_resp, '0);
    endtask

    // starts one request and checks latency and response
    task automatic apply_row(input row_t r);
        int   n;
        int   exp_latency;
        logic done_seen;
        exp_latency = r.req.ir[`EXEC_TWO_OPERAND_BIT] ? 4 : 3;
        n           = 0;
        done_seen   = 1'b0;
        i_req       = r.req;
        i_start     = 1'b1;
        @(posedge i_w_clk);
        #2;
        i_start = 1'b0;
        while (!done_seen) begin
            @(negedge i_w_clk);
            n++;
            if (o_done) begin
                done_seen = 1'b1;
            end else if (n > 6) begin
                stop_on_error("o_done never came after an accepted start");
            end else begin
                check_value("o_busy", o_busy, 1'b1);
                check_value("o_resp", o_resp, '0);
                @(posedge i_w_clk);
                #2;
                i_start = r.start_while_busy && (n == 1);
            end
        end
        check_value("done latency", n, exp_latency);
        check_value("o_busy", o_busy, 1'b1);
        check_value("o_resp.result", o_resp.result, r.exp_result);
        check_value("o_resp.carry_out", o_resp.carry_out, r.exp_carry);
        check_value("o_resp.illegal", o_resp.illegal, r.exp_illegal);
        // no second done may follow
        @(posedge i_w_clk);
        #2;
        @(negedge i_w_clk);
        check_idle();
        @(posedge i_w_clk);
        #2;
    endtask

    initial begin
        i_w_reset = 1'b0;
        i_start   = 1'b0;
        i_req     = '0;
        seed      = 32'h1e71;
        fill_table();
        repeat (10) @(posedge i_w_clk);
        #2;
        i_w_reset = 1'b1;
        @(negedge i_w_clk);
        check_idle();
        @(posedge i_w_clk);
        #2;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            build_random_row(rand_row);
            apply_row(rand_row);
        end
        if (dut.unit_props.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_on_error("a concurrent assertion on the DUT ports failed");
        end
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/exec_pkg.sv
verilog/operand_register.sv
verilog/execute_alu.sv
verilog/execute_sequencer.sv
verilog/execute_unit.sv
verification/execute_unit_properties.sv
verification/execute_unit_tb.sv

/* Bender.yml */
package:
  name: execute_unit

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exec_pkg.sv
      - verilog/operand_register.sv
      - verilog/execute_alu.sv
      - verilog/execute_sequencer.sv
      - verilog/execute_unit.sv

  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/execute_unit_properties.sv
      - verification/execute_unit_tb.sv
